//--- tests/core_cases.txt
// Word 0 is the case count. Per case: name index, program length N, N instruction words,
// store count M, then M pairs of store byte address and store data
00000004
// alu_forward
00000000 00000012
00500093 00708113 002081B3 40118233 0F024293 00302023
00402223 00502423 12345337 67836393 0FF3F413 0083C4B3
0040A533 00A4E5B3 0075F633 00B02623 00C02823 0000006F
00000005
00000000 00000011  00000004 0000000C  00000008 000000FC
0000000C 12345601  00000010 12345600
// load_use
00000001 00000008
02A00093 02102023 02002103 00110193 02302223 02402203
02402423 0000006F
00000003
00000020 0000002A  00000024 0000002B  00000028 0000002B
// branch_jump
00000002 00000011
00300093 00300113 00208663 00102023 00202223 00209463
05500193 00302423 00C002EF 00102623 00202623 00502823
00009463 00102A23 00008463 00102C23 0000006F
00000003
00000008 00000055  00000010 00000024  00000018 00000003
// x0_write
00000003 00000009
00700013 00900093 00108033 00002023 00100133 00202223
ABCDE037 00002423 0000006F
00000003
00000000 00000000  00000004 00000009  00000008 00000000

//--- rv_core.f
+incdir+hdl
hdl/rv_core_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/core.sv
tests/core_checker.sv
tests/core_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f rv_core.f \
    --top-module core_tb -Mdir obj_dir -o core_sim

result=$(./obj_dir/core_sim || true)
printf '%s\n' "$result"
printf '%s\n' "$result" | grep -q "^Simulation completed successfully$"

//--- tests/core_tb.sv
`timescale 1ns/1ns

module core_tb;
    import rv_core_pkg::*;

    localparam int CASE_WORDS = 256;
    localparam int MEM_WORDS  = 256;

    logic       clk = 1'b0;
    logic       rst_n = 1'b0;
    logic       instr_blocking_n = 1'b1;
    logic       data_blocking_n = 1'b1;
    word_t      instr_data;
    word_t      data_rdata;
    waddr_t     instr_addr;
    waddr_t     data_addr;
    logic [3:0] data_we;
    word_t      data_wdata;
    logic       data_en;

    logic [31:0] case_mem [CASE_WORDS];
    word_t       imem [MEM_WORDS];
    word_t       dmem [MEM_WORDS];
    string       case_names [4] = '{"alu_forward", "load_use", "branch_jump", "x0_write"};
    int          seed = 33;
    bit          random_blocking = 1'b0;
    int          cycle_count = 0;
    int          cycle_limit = 200;
    int          mismatch_count;
    int          missing_count;
    int          extra_count;

    always #50 clk = ~clk;

    core dut0 (
        .clk_i(clk), .rst_n_i(rst_n),
        .instr_cache_blocking_n_i(instr_blocking_n),
        .data_cache_blocking_n_i(data_blocking_n),
        .instr_cache_data_i(instr_data), .data_cache_data_i(data_rdata),
        .instr_cache_address_o(instr_addr), .data_cache_address_o(data_addr),
        .data_cache_write_en_o(data_we), .data_cache_data_o(data_wdata),
        .data_cache_enabled_o(data_en)
    );

    core_checker store_check0 (
        .clk_i(clk), .rst_n_i(rst_n),
        .instr_cache_blocking_n_i(instr_blocking_n),
        .data_cache_blocking_n_i(data_blocking_n),
        .data_cache_enabled_i(data_en), .data_cache_write_en_i(data_we),
        .data_cache_address_i(data_addr), .data_cache_data_i(data_wdata),
        .mismatch_count_o(mismatch_count), .missing_count_o(missing_count),
        .extra_count_o(extra_count)
    );

    // Both caches answer in the same cycle
    assign instr_data = imem[instr_addr[7:0]];
    assign data_rdata = dmem[data_addr[7:0]];

    always @(posedge clk) begin
        if (data_en && data_we == 4'hF && data_blocking_n) begin
            dmem[data_addr[7:0]] = data_wdata;
        end
    end

    always @(posedge clk) begin
        #5;
        if (random_blocking && rst_n) begin
            instr_blocking_n = (($random(seed) & 3) != 0);  // Low about one cycle in four
            data_blocking_n  = (($random(seed) & 3) != 0);
        end else begin
            instr_blocking_n = 1'b1;
            data_blocking_n  = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles: the core hangs before a program ends",
                     cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    // Loads one program, runs it from reset and waits for its self-jump to loop back
    task automatic run_case(input int base, output int next);
        int  prog_len;
        int  store_cnt;
        int  k;
        int  last_idx;
        bit  past_end;
        prog_len  = case_mem[base+1];
        store_cnt = case_mem[base+2+prog_len];
        rst_n = 1'b0;
        for (k = 0; k < MEM_WORDS; k++) begin
            imem[k] = '0;
            dmem[k] = '0;
        end
        for (k = 0; k < prog_len; k++) begin
            imem[k] = case_mem[base+2+k];
        end
        store_check0.start_case(case_names[case_mem[base]]);
        for (k = 0; k < store_cnt; k++) begin
            store_check0.expect_store(case_mem[base+3+prog_len+2*k],
                                      case_mem[base+4+prog_len+2*k]);
        end
        repeat (8) @(posedge clk);
        #5 rst_n = 1'b1;
        last_idx = prog_len - 1;
        past_end = 1'b0;
        while (!(past_end && instr_addr == waddr_t'(last_idx))) begin
            @(negedge clk);
            if (instr_addr == waddr_t'(last_idx + 2)) past_end = 1'b1;  // Wrong-path fetch
        end
        store_check0.finish_case();
        @(posedge clk);
        #5;
        next = base + 3 + prog_len + 2 * store_cnt;
    endtask

    initial begin
        int ptr;
        int count;
        int total_words;
        int c;
        int pass;
        $readmemh("tests/core_cases.txt", case_mem);
        count       = case_mem[0];
        total_words = 0;
        ptr         = 1;
        for (c = 0; c < count; c++) begin
            total_words += case_mem[ptr+1];
            ptr += 3 + case_mem[ptr+1] + 2 * case_mem[ptr+2+case_mem[ptr+1]];
        end
        cycle_limit = 40 * 2 * total_words + 200;  // Every program runs twice
        for (pass = 0; pass < 2; pass++) begin
            random_blocking = (pass == 1);
            ptr = 1;
            for (c = 0; c < count; c++) begin
                run_case(ptr, ptr);
            end
        end
        $display("Errors: %0d mismatched, %0d missing, %0d extra stores",
                 mismatch_count, missing_count, extra_count);
        if (mismatch_count + missing_count + extra_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- tests/core_checker.sv
`timescale 1ns/1ns

module core_checker (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 instr_cache_blocking_n_i,
    input  logic                 data_cache_blocking_n_i,
    input  logic                 data_cache_enabled_i,
    input  logic [3:0]           data_cache_write_en_i,
    input  rv_core_pkg::waddr_t  data_cache_address_i,
    input  rv_core_pkg::word_t   data_cache_data_i,
    output int                   mismatch_count_o,
    output int                   missing_count_o,
    output int                   extra_count_o
);
    import rv_core_pkg::*;

    string case_name = "none";
    word_t exp_addr_q [$];
    word_t exp_data_q [$];
    int    mismatch_count = 0;
    int    missing_count = 0;
    int    extra_count = 0;

    assign mismatch_count_o = mismatch_count;
    assign missing_count_o  = missing_count;
    assign extra_count_o    = extra_count;

    task automatic start_case(input string name);
        case_name = name;
    endtask

    task automatic expect_store(input word_t addr, input word_t data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    task automatic finish_case();
        if (exp_addr_q.size() != 0) begin
            $display("Missing stores in %s: %0d expected stores never reached the data cache",
                     case_name, exp_addr_q.size());
            missing_count += exp_addr_q.size();
            exp_addr_q.delete();
            exp_data_q.delete();
        end
    endtask

    // Sampled mid-cycle, after the blocking inputs have settled
    always @(negedge clk_i) begin
        word_t addr;
        if (rst_n_i && data_cache_enabled_i && data_cache_write_en_i == 4'hF &&
            instr_cache_blocking_n_i && data_cache_blocking_n_i) begin
            addr = {data_cache_address_i, 2'b00};
            if (exp_addr_q.size() == 0) begin
                $display("Extra store in %s: address %h, data %h was not expected",
                         case_name, addr, data_cache_data_i);
                extra_count++;
            end else begin
                if (addr !== exp_addr_q[0]) begin
                    $display("[FAIL] %s store address: expected %h, actual %h",
                             case_name, exp_addr_q[0], addr);
                    mismatch_count++;
                end
                if (data_cache_data_i !== exp_data_q[0]) begin
                    $display("[FAIL] %s store data at %h: expected %h, actual %h",
                             case_name, exp_addr_q[0], exp_data_q[0], data_cache_data_i);
                    mismatch_count++;
                end
                exp_addr_q.delete(0);
                exp_data_q.delete(0);
            end
        end
    end

endmodule

//--- hdl/core.sv
`timescale 1ns/1ns

module core (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 instr_cache_blocking_n_i,
    input  logic                 data_cache_blocking_n_i,
    input  rv_core_pkg::word_t   instr_cache_data_i,
    input  rv_core_pkg::word_t   data_cache_data_i,
    output rv_core_pkg::waddr_t  instr_cache_address_o,
    output rv_core_pkg::waddr_t  data_cache_address_o,
    output logic [3:0]           data_cache_write_en_o,
    output rv_core_pkg::word_t   data_cache_data_o,
    output logic                 data_cache_enabled_o
);
    import rv_core_pkg::*;

    logic     freeze;
    logic     load_stall;
    logic     redirect;
    word_t    redirect_pc;

    word_t    if_instr;
    word_t    if_pc;
    logic     if_valid;

    word_t    id_rs1_val;
    word_t    id_rs2_val;
    word_t    id_imm;
    word_t    id_pc;
    reg_idx_t id_rs1;
    reg_idx_t id_rs2;
    reg_idx_t id_rd;
    alu_op_t  id_alu_op;
    logic     id_op1_pc;
    logic     id_op2_imm;
    logic     id_reg_wb_en;
    logic     id_is_load;
    logic     id_is_store;
    logic     id_is_branch;
    logic     id_branch_ne;
    logic     id_is_jump;
    wb_sel_t  id_wb_sel;

    word_t    ex_result;
    word_t    ex_store_data;
    word_t    ex_pc4;
    reg_idx_t ex_rd;
    logic     ex_reg_wb_en;
    logic     ex_is_load;
    logic     ex_is_store;
    wb_sel_t  ex_wb_sel;

    word_t    mem_data;
    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;

    assign freeze = !instr_cache_blocking_n_i || !data_cache_blocking_n_i;  // Whole pipe holds

    fetch_stage fetch0 (
        .clk_i, .rst_n_i,
        .freeze_i(freeze), .stall_i(load_stall),
        .redirect_i(redirect), .redirect_pc_i(redirect_pc),
        .instr_cache_data_i, .instr_cache_address_o,
        .instr_o(if_instr), .pc_o(if_pc), .valid_o(if_valid)
    );

    decode_stage decode0 (
        .clk_i, .rst_n_i,
        .freeze_i(freeze), .flush_i(redirect),
        .instr_i(if_instr), .pc_i(if_pc), .valid_i(if_valid),
        .wb_en_i(wb_en), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
        .load_stall_o(load_stall),
        .rs1_val_o(id_rs1_val), .rs2_val_o(id_rs2_val), .imm_o(id_imm), .pc_o(id_pc),
        .rs1_o(id_rs1), .rs2_o(id_rs2), .rd_o(id_rd), .alu_op_o(id_alu_op),
        .op1_pc_o(id_op1_pc), .op2_imm_o(id_op2_imm), .reg_wb_en_o(id_reg_wb_en),
        .is_load_o(id_is_load), .is_store_o(id_is_store), .is_branch_o(id_is_branch),
        .branch_ne_o(id_branch_ne), .is_jump_o(id_is_jump), .wb_sel_o(id_wb_sel)
    );

    execute_stage execute0 (
        .clk_i, .rst_n_i, .freeze_i(freeze),
        .rs1_val_i(id_rs1_val), .rs2_val_i(id_rs2_val), .imm_i(id_imm), .pc_i(id_pc),
        .rs1_i(id_rs1), .rs2_i(id_rs2), .rd_i(id_rd), .alu_op_i(id_alu_op),
        .op1_pc_i(id_op1_pc), .op2_imm_i(id_op2_imm), .reg_wb_en_i(id_reg_wb_en),
        .is_load_i(id_is_load), .is_store_i(id_is_store), .is_branch_i(id_is_branch),
        .branch_ne_i(id_branch_ne), .is_jump_i(id_is_jump), .wb_sel_i(id_wb_sel),
        .mem_rd_i(ex_rd), .mem_wb_en_i(ex_reg_wb_en), .mem_data_i(mem_data),
        .wb_rd_i(wb_rd), .wb_en_i(wb_en), .wb_data_i(wb_data),
        .redirect_o(redirect), .redirect_pc_o(redirect_pc),
        .result_o(ex_result), .store_data_o(ex_store_data), .pc4_o(ex_pc4),
        .rd_o(ex_rd), .reg_wb_en_o(ex_reg_wb_en), .is_load_o(ex_is_load),
        .is_store_o(ex_is_store), .wb_sel_o(ex_wb_sel)
    );

    memory_stage memory0 (
        .clk_i, .rst_n_i, .freeze_i(freeze),
        .result_i(ex_result), .store_data_i(ex_store_data), .pc4_i(ex_pc4),
        .rd_i(ex_rd), .reg_wb_en_i(ex_reg_wb_en), .is_load_i(ex_is_load),
        .is_store_i(ex_is_store), .wb_sel_i(ex_wb_sel),
        .data_cache_data_i, .data_cache_address_o, .data_cache_write_en_o,
        .data_cache_data_o, .data_cache_enabled_o,
        .mem_data_o(mem_data),
        .wb_en_o(wb_en), .wb_rd_o(wb_rd), .wb_data_o(wb_data)
    );

endmodule

//--- hdl/memory_stage.sv
`timescale 1ns/1ns

module memory_stage (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   freeze_i,
    input  rv_core_pkg::word_t     result_i,
    input  rv_core_pkg::word_t     store_data_i,
    input  rv_core_pkg::word_t     pc4_i,
    input  rv_core_pkg::reg_idx_t  rd_i,
    input  logic                   reg_wb_en_i,
    input  logic                   is_load_i,
    input  logic                   is_store_i,
    input  rv_core_pkg::wb_sel_t   wb_sel_i,
    input  rv_core_pkg::word_t     data_cache_data_i,
    output rv_core_pkg::waddr_t    data_cache_address_o,
    output logic [3:0]             data_cache_write_en_o,
    output rv_core_pkg::word_t     data_cache_data_o,
    output logic                   data_cache_enabled_o,
    output rv_core_pkg::word_t     mem_data_o,
    output logic                   wb_en_o,
    output rv_core_pkg::reg_idx_t  wb_rd_o,
    output rv_core_pkg::word_t     wb_data_o
);
    import rv_core_pkg::*;

    logic wb_en_q;

    // Access is only requested in the cycle the instruction leaves, so a store lands once
    assign data_cache_enabled_o  = (is_load_i || is_store_i) && !freeze_i;
    assign data_cache_write_en_o = {4{is_store_i && !freeze_i}};
    assign data_cache_address_o  = result_i[31:2];
    assign data_cache_data_o     = store_data_i;

    // Final value of the instruction in this stage, also the EX/MEM forward
    always_comb begin
        case (wb_sel_i)
            WB_LOAD: mem_data_o = data_cache_data_i;
            WB_PC4:  mem_data_o = pc4_i;
            default: mem_data_o = result_i;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_en_q <= 1'b0;
        end else if (!freeze_i) begin
            wb_en_q <= reg_wb_en_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!freeze_i) begin
            wb_rd_o   <= rd_i;
            wb_data_o <= mem_data_o;
        end
    end

    assign wb_en_o = wb_en_q && !freeze_i;  // No register write while frozen

    store_enable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_cache_write_en_o != 4'b0 |-> data_cache_enabled_o && !is_load_i)
        else $error("data cache write without a store request");

endmodule

//--- hdl/execute_stage.sv
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module execute_stage (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   freeze_i,
    input  rv_core_pkg::word_t     rs1_val_i,
    input  rv_core_pkg::word_t     rs2_val_i,
    input  rv_core_pkg::word_t     imm_i,
    input  rv_core_pkg::word_t     pc_i,
    input  rv_core_pkg::reg_idx_t  rs1_i,
    input  rv_core_pkg::reg_idx_t  rs2_i,
    input  rv_core_pkg::reg_idx_t  rd_i,
    input  rv_core_pkg::alu_op_t   alu_op_i,
    input  logic                   op1_pc_i,
    input  logic                   op2_imm_i,
    input  logic                   reg_wb_en_i,
    input  logic                   is_load_i,
    input  logic                   is_store_i,
    input  logic                   is_branch_i,
    input  logic                   branch_ne_i,
    input  logic                   is_jump_i,
    input  rv_core_pkg::wb_sel_t   wb_sel_i,
    input  rv_core_pkg::reg_idx_t  mem_rd_i,
    input  logic                   mem_wb_en_i,
    input  rv_core_pkg::word_t     mem_data_i,
    input  rv_core_pkg::reg_idx_t  wb_rd_i,
    input  logic                   wb_en_i,
    input  rv_core_pkg::word_t     wb_data_i,
    output logic                   redirect_o,
    output rv_core_pkg::word_t     redirect_pc_o,
    output rv_core_pkg::word_t     result_o,
    output rv_core_pkg::word_t     store_data_o,
    output rv_core_pkg::word_t     pc4_o,
    output rv_core_pkg::reg_idx_t  rd_o,
    output logic                   reg_wb_en_o,
    output logic                   is_load_o,
    output logic                   is_store_o,
    output rv_core_pkg::wb_sel_t   wb_sel_o
);
    import rv_core_pkg::*;

    fwd_sel_t fwd_a_sel;
    fwd_sel_t fwd_b_sel;
    word_t    op_a;
    word_t    op_b;
    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_res;

    // Youngest producer wins
    function automatic fwd_sel_t pick_source(reg_idx_t rs);
        if (rs == '0) return FWD_REG;
        if (mem_wb_en_i && mem_rd_i == rs) return FWD_MEM;
        if (wb_en_i && wb_rd_i == rs) return FWD_WB;
        return FWD_REG;
    endfunction

    function automatic word_t fwd_value(fwd_sel_t sel, word_t reg_val);
        case (sel)
            FWD_MEM: return mem_data_i;
            FWD_WB:  return wb_data_i;
            default: return reg_val;
        endcase
    endfunction

    assign fwd_a_sel = pick_source(rs1_i);
    assign fwd_b_sel = pick_source(rs2_i);
    assign op_a      = fwd_value(fwd_a_sel, rs1_val_i);
    assign op_b      = fwd_value(fwd_b_sel, rs2_val_i);
    assign alu_a     = op1_pc_i ? pc_i : op_a;
    assign alu_b     = op2_imm_i ? imm_i : op_b;

    always_comb begin
        case (alu_op_i)
            ALU_SUB:   alu_res = alu_a - alu_b;
            ALU_AND:   alu_res = alu_a & alu_b;
            ALU_OR:    alu_res = alu_a | alu_b;
            ALU_XOR:   alu_res = alu_a ^ alu_b;
            ALU_SLT:   alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            ALU_PASS2: alu_res = alu_b;
            default:   alu_res = alu_a + alu_b;
        endcase
    end

    // Branches and JAL put PC plus offset through the adder
    assign redirect_o    = is_jump_i || (is_branch_i && ((op_a == op_b) ^ branch_ne_i));
    assign redirect_pc_o = alu_res;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            reg_wb_en_o <= 1'b0;
            is_load_o   <= 1'b0;
            is_store_o  <= 1'b0;
        end else if (!freeze_i) begin
            reg_wb_en_o <= reg_wb_en_i;
            is_load_o   <= is_load_i;
            is_store_o  <= is_store_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!freeze_i) begin
            result_o     <= alu_res;
            store_data_o <= op_b;  // Forwarded rs2
            pc4_o        <= pc_i + 32'd4;
            rd_o         <= rd_i;
            wb_sel_o     <= wb_sel_i;
        end
    end

    // A MEM/WB forward is never taken while EX/MEM also holds the operand
    fwd_sel_legal_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(fwd_a_sel == FWD_WB && mem_wb_en_i && mem_rd_i == rs1_i) &&
        !(fwd_b_sel == FWD_WB && mem_wb_en_i && mem_rd_i == rs2_i))
        else $error("both forwarding sources selected for one operand");

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module decode_stage (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   freeze_i,
    input  logic                   flush_i,
    input  rv_core_pkg::word_t     instr_i,
    input  rv_core_pkg::word_t     pc_i,
    input  logic                   valid_i,
    input  logic                   wb_en_i,
    input  rv_core_pkg::reg_idx_t  wb_rd_i,
    input  rv_core_pkg::word_t     wb_data_i,
    output logic                   load_stall_o,
    output rv_core_pkg::word_t     rs1_val_o,
    output rv_core_pkg::word_t     rs2_val_o,
    output rv_core_pkg::word_t     imm_o,
    output rv_core_pkg::word_t     pc_o,
    output rv_core_pkg::reg_idx_t  rs1_o,
    output rv_core_pkg::reg_idx_t  rs2_o,
    output rv_core_pkg::reg_idx_t  rd_o,
    output rv_core_pkg::alu_op_t   alu_op_o,
    output logic                   op1_pc_o,
    output logic                   op2_imm_o,
    output logic                   reg_wb_en_o,
    output logic                   is_load_o,
    output logic                   is_store_o,
    output logic                   is_branch_o,
    output logic                   branch_ne_o,
    output logic                   is_jump_o,
    output rv_core_pkg::wb_sel_t   wb_sel_o
);
    import rv_core_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    word_t      regs [`RV_REG_COUNT];
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    logic [2:0] funct3;
    word_t      imm;
    alu_op_t    alu_op;
    wb_sel_t    wb_sel;
    logic       writes;
    logic       use_rs1;
    logic       use_rs2;
    logic       op1_pc;
    logic       op2_imm;
    logic       is_load;
    logic       is_store;
    logic       is_branch;
    logic       is_jump;
    logic       issue;

    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];
    assign rd     = instr_i[11:7];
    assign funct3 = instr_i[14:12];

    // Flag order: writes, use_rs1, use_rs2, op1_pc, op2_imm, load, store, branch, jump
    always_comb begin
        imm    = {{20{instr_i[31]}}, instr_i[31:20]};  // I-type unless overridden
        alu_op = ALU_ADD;
        wb_sel = WB_ALU;
        {writes, use_rs1, use_rs2, op1_pc, op2_imm,
         is_load, is_store, is_branch, is_jump} = '0;
        case (instr_i[6:0])
            OPC_OP: begin
                {writes, use_rs1, use_rs2} = 3'b111;
                case (funct3)
                    3'b000:  alu_op = instr_i[30] ? ALU_SUB : ALU_ADD;
                    3'b010:  alu_op = ALU_SLT;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: writes = 1'b0;  // Outside the subset
                endcase
            end
            OPC_IMM: begin
                {writes, use_rs1, op2_imm} = 3'b111;
                case (funct3)
                    3'b000:  alu_op = ALU_ADD;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: writes = 1'b0;
                endcase
            end
            OPC_LUI: begin
                imm    = {instr_i[31:12], 12'b0};
                alu_op = ALU_PASS2;
                {writes, op2_imm} = 2'b11;
            end
            OPC_LOAD: begin
                wb_sel = WB_LOAD;
                {writes, use_rs1, op2_imm, is_load} = 4'b1111;
            end
            OPC_STORE: begin
                imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
                {use_rs1, use_rs2, op2_imm, is_store} = 4'b1111;
            end
            OPC_BRANCH: begin  // ALU forms the target from PC and offset
                imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                       instr_i[30:25], instr_i[11:8], 1'b0};
                {use_rs1, use_rs2, op1_pc, op2_imm, is_branch} = 5'b11111;
            end
            OPC_JAL: begin
                imm    = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                          instr_i[20], instr_i[30:21], 1'b0};
                wb_sel = WB_PC4;
                {writes, op1_pc, op2_imm, is_jump} = 4'b1111;
            end
            default: ;
        endcase
    end

    // Load in ID/EX feeding this instruction
    assign load_stall_o = valid_i && is_load_o && reg_wb_en_o &&
                          ((use_rs1 && rd_o == rs1) || (use_rs2 && rd_o == rs2));
    assign issue = valid_i && !flush_i && !load_stall_o;

    function automatic word_t read_reg(reg_idx_t idx);
        if (idx == '0) return '0;
        if (wb_en_i && wb_rd_i == idx) return wb_data_i;  // Write-first bypass
        return regs[idx];
    endfunction

    always_ff @(posedge clk_i) begin
        if (wb_en_i) regs[wb_rd_i] <= wb_data_i;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            reg_wb_en_o <= 1'b0;
            is_load_o   <= 1'b0;
            is_store_o  <= 1'b0;
            is_branch_o <= 1'b0;
            is_jump_o   <= 1'b0;
        end else if (!freeze_i) begin
            reg_wb_en_o <= issue && writes && (rd != '0);
            is_load_o   <= issue && is_load;
            is_store_o  <= issue && is_store;
            is_branch_o <= issue && is_branch;
            is_jump_o   <= issue && is_jump;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!freeze_i) begin
            rs1_val_o   <= read_reg(rs1);
            rs2_val_o   <= read_reg(rs2);
            imm_o       <= imm;
            pc_o        <= pc_i;
            rs1_o       <= rs1;
            rs2_o       <= rs2;
            rd_o        <= rd;
            alu_op_o    <= alu_op;
            op1_pc_o    <= op1_pc;
            op2_imm_o   <= op2_imm;
            branch_ne_o <= funct3[0];
            wb_sel_o    <= wb_sel;
        end
    end

    // The write enable from MEM/WB must already exclude x0
    no_x0_write_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_en_i |-> wb_rd_i != '0)
        else $error("write to register 0 reached the register file");

endmodule

//--- hdl/fetch_stage.sv
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module fetch_stage (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 freeze_i,
    input  logic                 stall_i,
    input  logic                 redirect_i,
    input  rv_core_pkg::word_t   redirect_pc_i,
    input  rv_core_pkg::word_t   instr_cache_data_i,
    output rv_core_pkg::waddr_t  instr_cache_address_o,
    output rv_core_pkg::word_t   instr_o,
    output rv_core_pkg::word_t   pc_o,
    output logic                 valid_o
);
    import rv_core_pkg::*;

    word_t pc_q;

    assign instr_cache_address_o = pc_q[31:2];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q    <= `RV_RESET_PC;
            valid_o <= 1'b0;
        end else if (!freeze_i) begin
            if (redirect_i) begin
                pc_q    <= redirect_pc_i;
                valid_o <= 1'b0;  // Drop the wrong-path fetch
            end else if (!stall_i) begin
                pc_q    <= pc_q + 32'd4;
                valid_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!freeze_i && !stall_i) begin
            instr_o <= instr_cache_data_i;
            pc_o    <= pc_q;
        end
    end

    redirect_aligned_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        redirect_i |-> redirect_pc_i[1:0] == 2'b00)
        else $error("misaligned redirect target %h", redirect_pc_i);

endmodule

//--- hdl/rv_core_pkg.sv
`include "rv_core_defines.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0]               word_t;
    typedef logic [`RV_XLEN-3:0]               waddr_t;    // Byte address bits 31:2
    typedef logic [$clog2(`RV_REG_COUNT)-1:0]  reg_idx_t;
    typedef logic [3:0]                        alu_op_t;
    typedef logic [1:0]                        wb_sel_t;
    typedef logic [1:0]                        fwd_sel_t;

    localparam alu_op_t ALU_ADD   = 4'd0;
    localparam alu_op_t ALU_SUB   = 4'd1;
    localparam alu_op_t ALU_AND   = 4'd2;
    localparam alu_op_t ALU_OR    = 4'd3;
    localparam alu_op_t ALU_XOR   = 4'd4;
    localparam alu_op_t ALU_SLT   = 4'd5;
    localparam alu_op_t ALU_PASS2 = 4'd6;  // LUI passes the immediate through

    localparam wb_sel_t WB_ALU  = 2'd0;
    localparam wb_sel_t WB_LOAD = 2'd1;
    localparam wb_sel_t WB_PC4  = 2'd2;

    localparam fwd_sel_t FWD_REG = 2'd0;
    localparam fwd_sel_t FWD_MEM = 2'd1;
    localparam fwd_sel_t FWD_WB  = 2'd2;

endpackage

//--- hdl/rv_core_defines.svh
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

`define RV_XLEN       32
`define RV_REG_COUNT  32
`define RV_RESET_PC   32'h0000_0000  // Byte address of first fetch

`endif
